//--- processorPkg.sv
//----------------------------------------------------------------------
// Processor package
// Bus widths, block address map, CSR offsets and display defaults
//----------------------------------------------------------------------
package processorPkg;

	// Bus widths
	localparam int usiBusWidth    = 32;
	localparam int busAdrsBit     = 32;
	localparam int blockAdrsMap   = 4;
	localparam int csrAdrsWidth   = 16;
	localparam int usiReadLatency = 3;

	// Block field position in the bus address
	localparam int blockAdrsMsb = 31;
	localparam int blockAdrsLsb = 28;

	// Block map, slave index 0 is GPIO and index 1 is video
	localparam logic [blockAdrsMap-1:0] gpioAdrsMap = 4'h1;
	localparam logic [blockAdrsMap-1:0] vtbAdrsMap  = 4'h4;
	localparam int slaveCount = 2;
	localparam logic [slaveCount-1:0][blockAdrsMap-1:0] slaveAdrsMap = {vtbAdrsMap, gpioAdrsMap};

	// GPIO registers
	localparam logic [csrAdrsWidth-1:0] gpioLedCsr = 16'h0000;
	localparam logic [csrAdrsWidth-1:0] gpioRgbCsr = 16'h0001;

	// Video registers
	localparam logic [csrAdrsWidth-1:0] vtbCtrlCsr     = 16'h0000;
	localparam logic [csrAdrsWidth-1:0] vtbHdisplayCsr = 16'h0001;
	localparam logic [csrAdrsWidth-1:0] vtbHfrontCsr   = 16'h0002;
	localparam logic [csrAdrsWidth-1:0] vtbHbackCsr    = 16'h0003;
	localparam logic [csrAdrsWidth-1:0] vtbHpulseCsr   = 16'h0004;
	localparam logic [csrAdrsWidth-1:0] vtbVdisplayCsr = 16'h0005;
	localparam logic [csrAdrsWidth-1:0] vtbVfrontCsr   = 16'h0006;
	localparam logic [csrAdrsWidth-1:0] vtbVbackCsr    = 16'h0007;
	localparam logic [csrAdrsWidth-1:0] vtbVpulseCsr   = 16'h0008;
	localparam logic [csrAdrsWidth-1:0] vtbColorCsr    = 16'h0009;

	// Control register bits
	localparam int vtbEnableBit    = 0;
	localparam int vtbBackLightBit = 1;

	// Timing field widths
	localparam int hDisplayWidth = 11;
	localparam int hFrontWidth   = 7;
	localparam int hBackWidth    = 7;
	localparam int hPulseWidth   = 7;
	localparam int vDisplayWidth = 11;
	localparam int vFrontWidth   = 5;
	localparam int vBackWidth    = 5;
	localparam int vPulseWidth   = 5;

	// Line and frame counters, wide enough for the largest totals
	localparam int timingCntWidth = 12;

	// Default panel timing, 480x272
	localparam int defHdisplay = 480;
	localparam int defHfront   = 8;
	localparam int defHback    = 43;
	localparam int defHpulse   = 30;
	localparam int defVdisplay = 272;
	localparam int defVfront   = 12;
	localparam int defVback    = 4;
	localparam int defVpulse   = 10;

	localparam int colorDepth = 4;

endpackage

//--- usiBus.sv
//----------------------------------------------------------------------
// USI register bus
// Registers master requests, decodes the block field into per-slave
// strobes and gathers the slave read data back to the master
//----------------------------------------------------------------------
`timescale 1ns/10ps

module usiBus (
	input  logic                                                     sysClk,
	input  logic                                                     rstN,
	input  logic [processorPkg::usiBusWidth-1:0]                     usiWd,
	input  logic [processorPkg::busAdrsBit-1:0]                      usiAdrs,
	input  logic                                                     usiWEd,
	input  logic                                                     usiREd,
	output logic [processorPkg::usiBusWidth-1:0]                     usiRd,
	output logic                                                     usiRdVd,
	output logic [processorPkg::usiBusWidth-1:0]                     slvWd,
	output logic [processorPkg::csrAdrsWidth-1:0]                    slvAdrs,
	output logic [processorPkg::slaveCount-1:0]                      slvWEd,
	output logic [processorPkg::slaveCount-1:0]                      slvREd,
	input  logic [processorPkg::slaveCount*processorPkg::usiBusWidth-1:0] slvRd,
	input  logic [processorPkg::slaveCount-1:0]                      slvRdVd
);
	import processorPkg::*;

	logic [slaveCount-1:0] blockHit;
	logic [usiReadLatency-1:0] rdDelay;
	logic [usiBusWidth-1:0] rdGather;
	logic [usiBusWidth-1:0] rdWord;

	// Block field compare, one bit per slave
	always_comb
	begin
		for (int i = 0; i < slaveCount; i++)
		begin
			blockHit[i] = usiAdrs[blockAdrsMsb:blockAdrsLsb] == slaveAdrsMap[i];
		end
	end

	//------------------------------------------------------------------
	// Request stage
	//------------------------------------------------------------------
	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			slvWEd <= '0;
			slvREd <= '0;
		end
		else
		begin
			slvWEd <= {slaveCount{usiWEd}} & blockHit;
			slvREd <= {slaveCount{usiREd}} & blockHit;
		end
	end

	always_ff @(posedge sysClk)
	begin
		slvWd   <= usiWd;
		slvAdrs <= usiAdrs[csrAdrsWidth-1:0];
	end

	// OR of the valid slices is zero when nobody answers
	always_comb
	begin
		rdGather = '0;
		for (int i = 0; i < slaveCount; i++)
		begin
			if (slvRdVd[i])
				rdGather = rdGather | slvRd[i*usiBusWidth +: usiBusWidth];
		end
	end

	//------------------------------------------------------------------
	// Read return
	//------------------------------------------------------------------
	// Own copy of the read strobe so unmapped reads still complete
	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			rdDelay <= '0;
			usiRdVd <= 1'b0;
		end
		else
		begin
			rdDelay <= {rdDelay[usiReadLatency-2:0], usiREd};
			usiRdVd <= rdDelay[usiReadLatency-1];
		end
	end

	always_ff @(posedge sysClk)
	begin
		rdWord <= rdGather;
		usiRd  <= rdWord;
	end

endmodule

//--- gpioBlock.sv
//----------------------------------------------------------------------
// GPIO block
// Two LED bits and an RGB LED, with register readback
//----------------------------------------------------------------------
`timescale 1ns/10ps

module gpioBlock (
	input  logic                                  sysClk,
	input  logic                                  rstN,
	input  logic [processorPkg::usiBusWidth-1:0]  slvWd,
	input  logic [processorPkg::csrAdrsWidth-1:0] slvAdrs,
	input  logic                                  slvWEd,
	input  logic                                  slvREd,
	output logic [processorPkg::usiBusWidth-1:0]  slvRd,
	output logic                                  slvRdVd,
	output logic [1:0]                            led,
	output logic                                  ledR,
	output logic                                  ledG,
	output logic                                  ledB
);
	import processorPkg::*;

	logic [1:0] ledReg;
	logic [2:0] rgbReg;

	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			ledReg  <= '0;
			rgbReg  <= '0;
			slvRdVd <= 1'b0;
		end
		else
		begin
			slvRdVd <= slvREd;
			if (slvWEd)
			begin
				case (slvAdrs)
					gpioLedCsr: ledReg <= slvWd[1:0];
					gpioRgbCsr: rgbReg <= slvWd[2:0];
					default: ;
				endcase
			end
		end
	end

	// Readback, zero-extended
	always_ff @(posedge sysClk)
	begin
		if (slvREd)
		begin
			case (slvAdrs)
				gpioLedCsr: slvRd <= usiBusWidth'(ledReg);
				gpioRgbCsr: slvRd <= usiBusWidth'(rgbReg);
				default:    slvRd <= '0;
			endcase
		end
	end

	assign led  = ledReg;
	assign ledR = rgbReg[0];
	assign ledG = rgbReg[1];
	assign ledB = rgbReg[2];

endmodule

//--- videoCsr.sv
//----------------------------------------------------------------------
// Video CSR block
// Control, panel timing and colour registers with readback
//----------------------------------------------------------------------
`timescale 1ns/10ps

module videoCsr (
	input  logic                                    sysClk,
	input  logic                                    rstN,
	input  logic [processorPkg::usiBusWidth-1:0]    slvWd,
	input  logic [processorPkg::csrAdrsWidth-1:0]   slvAdrs,
	input  logic                                    slvWEd,
	input  logic                                    slvREd,
	output logic [processorPkg::usiBusWidth-1:0]    slvRd,
	output logic                                    slvRdVd,
	output logic                                    enable,
	output logic [processorPkg::hDisplayWidth-1:0]  hDisplay,
	output logic [processorPkg::hFrontWidth-1:0]    hFront,
	output logic [processorPkg::hBackWidth-1:0]     hBack,
	output logic [processorPkg::hPulseWidth-1:0]    hPulse,
	output logic [processorPkg::vDisplayWidth-1:0]  vDisplay,
	output logic [processorPkg::vFrontWidth-1:0]    vFront,
	output logic [processorPkg::vBackWidth-1:0]     vBack,
	output logic [processorPkg::vPulseWidth-1:0]    vPulse,
	output logic [3*processorPkg::colorDepth-1:0]   color,
	output logic                                    tftBackLight
);
	import processorPkg::*;

	logic [usiBusWidth-1:0] rdMux;

	//------------------------------------------------------------------
	// Register write
	//------------------------------------------------------------------
	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			enable       <= 1'b0;
			tftBackLight <= 1'b0;
			hDisplay     <= hDisplayWidth'(defHdisplay);
			hFront       <= hFrontWidth'(defHfront);
			hBack        <= hBackWidth'(defHback);
			hPulse       <= hPulseWidth'(defHpulse);
			vDisplay     <= vDisplayWidth'(defVdisplay);
			vFront       <= vFrontWidth'(defVfront);
			vBack        <= vBackWidth'(defVback);
			vPulse       <= vPulseWidth'(defVpulse);
			color        <= '0;
		end
		else if (slvWEd)
		begin
			case (slvAdrs)
				vtbCtrlCsr:
				begin
					enable       <= slvWd[vtbEnableBit];
					tftBackLight <= slvWd[vtbBackLightBit];
				end
				vtbHdisplayCsr: hDisplay <= slvWd[hDisplayWidth-1:0];
				vtbHfrontCsr:   hFront   <= slvWd[hFrontWidth-1:0];
				vtbHbackCsr:    hBack    <= slvWd[hBackWidth-1:0];
				vtbHpulseCsr:   hPulse   <= slvWd[hPulseWidth-1:0];
				vtbVdisplayCsr: vDisplay <= slvWd[vDisplayWidth-1:0];
				vtbVfrontCsr:   vFront   <= slvWd[vFrontWidth-1:0];
				vtbVbackCsr:    vBack    <= slvWd[vBackWidth-1:0];
				vtbVpulseCsr:   vPulse   <= slvWd[vPulseWidth-1:0];
				vtbColorCsr:    color    <= slvWd[3*colorDepth-1:0];
				default: ;
			endcase
		end
	end

	//------------------------------------------------------------------
	// Readback
	//------------------------------------------------------------------
	always_comb
	begin
		rdMux = '0;
		case (slvAdrs)
			vtbCtrlCsr:
			begin
				rdMux[vtbEnableBit]    = enable;
				rdMux[vtbBackLightBit] = tftBackLight;
			end
			vtbHdisplayCsr: rdMux = usiBusWidth'(hDisplay);
			vtbHfrontCsr:   rdMux = usiBusWidth'(hFront);
			vtbHbackCsr:    rdMux = usiBusWidth'(hBack);
			vtbHpulseCsr:   rdMux = usiBusWidth'(hPulse);
			vtbVdisplayCsr: rdMux = usiBusWidth'(vDisplay);
			vtbVfrontCsr:   rdMux = usiBusWidth'(vFront);
			vtbVbackCsr:    rdMux = usiBusWidth'(vBack);
			vtbVpulseCsr:   rdMux = usiBusWidth'(vPulse);
			vtbColorCsr:    rdMux = usiBusWidth'(color);
			default: ;
		endcase
	end

	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
			slvRdVd <= 1'b0;
		else
			slvRdVd <= slvREd;
	end

	always_ff @(posedge sysClk)
	begin
		if (slvREd)
			slvRd <= rdMux;
	end

endmodule

//--- videoTiming.sv
//----------------------------------------------------------------------
// Video timing generator
// Line and frame counters with registered sync, DE and fill colour
//----------------------------------------------------------------------
`timescale 1ns/10ps

module videoTiming (
	input  logic                                    sysClk,
	input  logic                                    rstN,
	input  logic                                    enable,
	input  logic [processorPkg::hDisplayWidth-1:0]  hDisplay,
	input  logic [processorPkg::hFrontWidth-1:0]    hFront,
	input  logic [processorPkg::hBackWidth-1:0]     hBack,
	input  logic [processorPkg::hPulseWidth-1:0]    hPulse,
	input  logic [processorPkg::vDisplayWidth-1:0]  vDisplay,
	input  logic [processorPkg::vFrontWidth-1:0]    vFront,
	input  logic [processorPkg::vBackWidth-1:0]     vBack,
	input  logic [processorPkg::vPulseWidth-1:0]    vPulse,
	input  logic [3*processorPkg::colorDepth-1:0]   color,
	output logic                                    tftHSync,
	output logic                                    tftVSync,
	output logic                                    tftDe,
	output logic [processorPkg::colorDepth-1:0]     tftColorR,
	output logic [processorPkg::colorDepth-1:0]     tftColorG,
	output logic [processorPkg::colorDepth-1:0]     tftColorB
);
	import processorPkg::*;

	logic [timingCntWidth-1:0] hCnt;
	logic [timingCntWidth-1:0] vCnt;
	logic [timingCntWidth-1:0] hSyncStart;
	logic [timingCntWidth-1:0] hSyncEnd;
	logic [timingCntWidth-1:0] hTotal;
	logic [timingCntWidth-1:0] vSyncStart;
	logic [timingCntWidth-1:0] vSyncEnd;
	logic [timingCntWidth-1:0] vTotal;
	logic hLast;
	logic vLast;
	logic hActive;
	logic vActive;
	logic deNext;

	//------------------------------------------------------------------
	// Region boundaries
	//------------------------------------------------------------------
	// Order is display, front porch, pulse, back porch
	assign hSyncStart = timingCntWidth'(hDisplay) + timingCntWidth'(hFront);
	assign hSyncEnd   = hSyncStart + timingCntWidth'(hPulse);
	assign hTotal     = hSyncEnd + timingCntWidth'(hBack);
	assign vSyncStart = timingCntWidth'(vDisplay) + timingCntWidth'(vFront);
	assign vSyncEnd   = vSyncStart + timingCntWidth'(vPulse);
	assign vTotal     = vSyncEnd + timingCntWidth'(vBack);

	assign hLast   = hCnt == hTotal - 1'b1;
	assign vLast   = vCnt == vTotal - 1'b1;
	assign hActive = hCnt < timingCntWidth'(hDisplay);
	assign vActive = vCnt < timingCntWidth'(vDisplay);
	assign deNext  = enable & hActive & vActive;

	//------------------------------------------------------------------
	// Counters
	//------------------------------------------------------------------
	// Held at zero while disabled, so the frame opens on a display cycle
	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			hCnt <= '0;
			vCnt <= '0;
		end
		else if (!enable)
		begin
			hCnt <= '0;
			vCnt <= '0;
		end
		else if (hLast)
		begin
			hCnt <= '0;
			vCnt <= vLast ? '0 : vCnt + 1'b1;
		end
		else
			hCnt <= hCnt + 1'b1;
	end

	//------------------------------------------------------------------
	// Panel outputs
	//------------------------------------------------------------------
	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			tftHSync  <= 1'b1;
			tftVSync  <= 1'b1;
			tftDe     <= 1'b0;
			tftColorR <= '0;
			tftColorG <= '0;
			tftColorB <= '0;
		end
		else
		begin
			tftHSync  <= ~(enable & (hCnt >= hSyncStart) & (hCnt < hSyncEnd));
			// Low for the whole of each pulse line
			tftVSync  <= ~(enable & (vCnt >= vSyncStart) & (vCnt < vSyncEnd));
			tftDe     <= deNext;
			tftColorR <= deNext ? color[2*colorDepth +: colorDepth] : '0;
			tftColorG <= deNext ? color[colorDepth +: colorDepth] : '0;
			tftColorB <= deNext ? color[0 +: colorDepth] : '0;
		end
	end

endmodule

//--- processor.sv
//----------------------------------------------------------------------
// Processor top level
// Register bus with the GPIO and video transmit blocks on sysClk
//----------------------------------------------------------------------
`timescale 1ns/10ps

module processor (
	input  logic                                 sysClk,
	input  logic                                 rstN,
	input  logic [processorPkg::usiBusWidth-1:0] usiWd,
	input  logic [processorPkg::busAdrsBit-1:0]  usiAdrs,
	input  logic                                 usiWEd,
	input  logic                                 usiREd,
	output logic [processorPkg::usiBusWidth-1:0] usiRd,
	output logic                                 usiRdVd,
	output logic [1:0]                           led,
	output logic                                 ledR,
	output logic                                 ledG,
	output logic                                 ledB,
	output logic [processorPkg::colorDepth-1:0]  tftColorR,
	output logic [processorPkg::colorDepth-1:0]  tftColorG,
	output logic [processorPkg::colorDepth-1:0]  tftColorB,
	output logic                                 tftHSync,
	output logic                                 tftVSync,
	output logic                                 tftDe,
	output logic                                 tftBackLight
);
	import processorPkg::*;

	// Bus to slaves
	logic [usiBusWidth-1:0] slvWd;
	logic [csrAdrsWidth-1:0] slvAdrs;
	logic [slaveCount-1:0] slvWEd;
	logic [slaveCount-1:0] slvREd;
	logic [slaveCount*usiBusWidth-1:0] slvRd;
	logic [slaveCount-1:0] slvRdVd;

	// Video registers to the timing generator
	logic enable;
	logic [hDisplayWidth-1:0] hDisplay;
	logic [hFrontWidth-1:0] hFront;
	logic [hBackWidth-1:0] hBack;
	logic [hPulseWidth-1:0] hPulse;
	logic [vDisplayWidth-1:0] vDisplay;
	logic [vFrontWidth-1:0] vFront;
	logic [vBackWidth-1:0] vBack;
	logic [vPulseWidth-1:0] vPulse;
	logic [3*colorDepth-1:0] color;

	usiBus u_usiBus (
		.sysClk  (sysClk),
		.rstN    (rstN),
		.usiWd   (usiWd),
		.usiAdrs (usiAdrs),
		.usiWEd  (usiWEd),
		.usiREd  (usiREd),
		.usiRd   (usiRd),
		.usiRdVd (usiRdVd),
		.slvWd   (slvWd),
		.slvAdrs (slvAdrs),
		.slvWEd  (slvWEd),
		.slvREd  (slvREd),
		.slvRd   (slvRd),
		.slvRdVd (slvRdVd)
	);

	// Slave 0
	gpioBlock u_gpioBlock (
		.sysClk  (sysClk),
		.rstN    (rstN),
		.slvWd   (slvWd),
		.slvAdrs (slvAdrs),
		.slvWEd  (slvWEd[0]),
		.slvREd  (slvREd[0]),
		.slvRd   (slvRd[0 +: usiBusWidth]),
		.slvRdVd (slvRdVd[0]),
		.led     (led),
		.ledR    (ledR),
		.ledG    (ledG),
		.ledB    (ledB)
	);

	// Slave 1
	videoCsr u_videoCsr (
		.sysClk       (sysClk),
		.rstN         (rstN),
		.slvWd        (slvWd),
		.slvAdrs      (slvAdrs),
		.slvWEd       (slvWEd[1]),
		.slvREd       (slvREd[1]),
		.slvRd        (slvRd[usiBusWidth +: usiBusWidth]),
		.slvRdVd      (slvRdVd[1]),
		.enable       (enable),
		.hDisplay     (hDisplay),
		.hFront       (hFront),
		.hBack        (hBack),
		.hPulse       (hPulse),
		.vDisplay     (vDisplay),
		.vFront       (vFront),
		.vBack        (vBack),
		.vPulse       (vPulse),
		.color        (color),
		.tftBackLight (tftBackLight)
	);

	videoTiming u_videoTiming (
		.sysClk    (sysClk),
		.rstN      (rstN),
		.enable    (enable),
		.hDisplay  (hDisplay),
		.hFront    (hFront),
		.hBack     (hBack),
		.hPulse    (hPulse),
		.vDisplay  (vDisplay),
		.vFront    (vFront),
		.vBack     (vBack),
		.vPulse    (vPulse),
		.color     (color),
		.tftHSync  (tftHSync),
		.tftVSync  (tftVSync),
		.tftDe     (tftDe),
		.tftColorR (tftColorR),
		.tftColorG (tftColorG),
		.tftColorB (tftColorB)
	);

endmodule

//--- tbProcessor.sv
//----------------------------------------------------------------------
// Processor testbench
// Random register traffic through the bus and video timing checks,
// both compared against a register model kept in the testbench
//----------------------------------------------------------------------
`timescale 1ns/10ps

module tbProcessor;
	import processorPkg::*;

	localparam int clkPeriod     = 100;
	localparam int resetCycles   = 2;
	localparam int busTestCycles = 1200;
	// Largest random line is 20 display cycles plus three values of 6
	localparam int maxLineCycles  = 20 + 3 * 6;
	localparam int maxFrameCycles = maxLineCycles * maxLineCycles;
	localparam int watchdogCycles = resetCycles + busTestCycles + 3 * maxFrameCycles;
	localparam logic [blockAdrsMap-1:0] unmappedBlock = 4'h7;

	logic sysClk;
	logic rstN;
	logic [usiBusWidth-1:0] usiWd;
	logic [busAdrsBit-1:0] usiAdrs;
	logic usiWEd;
	logic usiREd;
	logic [usiBusWidth-1:0] usiRd;
	logic usiRdVd;
	logic [1:0] led;
	logic ledR;
	logic ledG;
	logic ledB;
	logic [colorDepth-1:0] tftColorR;
	logic [colorDepth-1:0] tftColorG;
	logic [colorDepth-1:0] tftColorB;
	logic tftHSync;
	logic tftVSync;
	logic tftDe;
	logic tftBackLight;

	logic [31:0] lfsrState;
	int cycle;
	logic [usiBusWidth-1:0] gpioModel [0:1];
	logic [usiBusWidth-1:0] videoModel [0:9];
	// Expected read words and the edge that sampled each strobe
	logic [usiBusWidth-1:0] expQ [$];
	int issueQ [$];
	// Timing programmed for the video test
	int tHd, tHf, tHb, tHp;
	int tVd, tVf, tVb, tVp;
	logic [3*colorDepth-1:0] tColor;

	processor u_processor (.*);

	initial
	begin
		sysClk = 1'b0;
		forever #(clkPeriod / 2) sysClk = ~sysClk;
	end

	always @(posedge sysClk)
		cycle <= cycle + 1;

	//------------------------------------------------------------------
	// Random numbers and register model
	//------------------------------------------------------------------
	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	function automatic logic [31:0] randBits(input int count);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++)
		begin
			lfsrState = lfsrNext(lfsrState);
			bits = {bits[30:0], lfsrState[0]};
		end
		return bits;
	endfunction

	function automatic int randRange(input int lo, input int hi);
		logic [31:0] bits;
		bits = randBits(8);
		return lo + int'(bits) % (hi - lo + 1);
	endfunction

	// Ignored address bits 27 to 16 get random filler
	function automatic logic [busAdrsBit-1:0] makeAdrs(input logic [blockAdrsMap-1:0] block,
		input logic [csrAdrsWidth-1:0] offset);
		logic [31:0] filler;
		filler = randBits(12);
		return {block, filler[11:0], offset};
	endfunction

	function automatic logic [busAdrsBit-1:0] randomAdrs();
		logic [busAdrsBit-1:0] adrs;
		logic [31:0] sel;
		sel = randBits(2);
		if (sel == 0)
			adrs = makeAdrs(gpioAdrsMap, 16'(randRange(0, 3)));
		else if (sel == 3)
			adrs = makeAdrs(unmappedBlock, 16'(randRange(0, 15)));
		else
			adrs = makeAdrs(vtbAdrsMap, 16'(randRange(0, 15)));
		return adrs;
	endfunction

	function automatic logic [usiBusWidth-1:0] widthMask(input int width);
		return (32'd1 << width) - 32'd1;
	endfunction

	// Zero mask marks an unmapped block or offset
	function automatic logic [usiBusWidth-1:0] fieldMask(input logic [busAdrsBit-1:0] adrs);
		logic [usiBusWidth-1:0] mask;
		mask = '0;
		if (adrs[31:28] == gpioAdrsMap)
		begin
			case (adrs[15:0])
				16'd0: mask = widthMask(2);
				16'd1: mask = widthMask(3);
				default: mask = '0;
			endcase
		end
		else if (adrs[31:28] == vtbAdrsMap)
		begin
			case (adrs[15:0])
				16'd0: mask = widthMask(2);
				16'd1: mask = widthMask(hDisplayWidth);
				16'd2: mask = widthMask(hFrontWidth);
				16'd3: mask = widthMask(hBackWidth);
				16'd4: mask = widthMask(hPulseWidth);
				16'd5: mask = widthMask(vDisplayWidth);
				16'd6: mask = widthMask(vFrontWidth);
				16'd7: mask = widthMask(vBackWidth);
				16'd8: mask = widthMask(vPulseWidth);
				16'd9: mask = widthMask(3 * colorDepth);
				default: mask = '0;
			endcase
		end
		return mask;
	endfunction

	task automatic resetModel();
		gpioModel[0] = '0;
		gpioModel[1] = '0;
		videoModel[0] = '0;
		videoModel[1] = 32'(defHdisplay);
		videoModel[2] = 32'(defHfront);
		videoModel[3] = 32'(defHback);
		videoModel[4] = 32'(defHpulse);
		videoModel[5] = 32'(defVdisplay);
		videoModel[6] = 32'(defVfront);
		videoModel[7] = 32'(defVback);
		videoModel[8] = 32'(defVpulse);
		videoModel[9] = '0;
	endtask

	task automatic modelWrite(input logic [busAdrsBit-1:0] adrs,
		input logic [usiBusWidth-1:0] data);
		logic [usiBusWidth-1:0] mask;
		mask = fieldMask(adrs);
		if (mask != '0)
		begin
			if (adrs[31:28] == gpioAdrsMap)
				gpioModel[adrs[0]] = data & mask;
			else
				videoModel[adrs[3:0]] = data & mask;
		end
	endtask

	function automatic logic [usiBusWidth-1:0] modelRead(input logic [busAdrsBit-1:0] adrs);
		logic [usiBusWidth-1:0] value;
		value = '0;
		if (fieldMask(adrs) != '0)
		begin
			if (adrs[31:28] == gpioAdrsMap)
				value = gpioModel[adrs[0]];
			else
				value = videoModel[adrs[3:0]];
		end
		return value;
	endfunction

	//------------------------------------------------------------------
	// Compare tasks
	//------------------------------------------------------------------
	task automatic compareWord(input string name, input logic [usiBusWidth-1:0] expected,
		input logic [usiBusWidth-1:0] actual);
		if (actual !== expected)
		begin
			$display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
			$display("RESULT: FAIL");
			$fatal(1, "Bus word check failed");
		end
	endtask

	task automatic compareLed(input string name, input logic [1:0] expected,
		input logic [1:0] actual);
		if (actual !== expected)
		begin
			$display("Mismatch at %0t: %s expected %b, got %b", $time, name, expected, actual);
			$display("RESULT: FAIL");
			$fatal(1, "Pin check failed");
		end
	endtask

	task automatic compareColor(input string name, input logic [colorDepth-1:0] expected,
		input logic [colorDepth-1:0] actual);
		if (actual !== expected)
		begin
			$display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
			$display("RESULT: FAIL");
			$fatal(1, "Colour check failed");
		end
	endtask

	task automatic compareCount(input string name, input int expected, input int actual);
		if (actual != expected)
		begin
			$display("Mismatch at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
			$display("RESULT: FAIL");
			$fatal(1, "Count check failed");
		end
	endtask

	task automatic checkPins();
		compareLed("led", gpioModel[0][1:0], led);
		compareLed("ledR", 2'(gpioModel[1][0]), 2'(ledR));
		compareLed("ledG", 2'(gpioModel[1][1]), 2'(ledG));
		compareLed("ledB", 2'(gpioModel[1][2]), 2'(ledB));
		compareLed("tftBackLight", 2'(videoModel[0][1]), 2'(tftBackLight));
	endtask

	task automatic checkVideoIdle();
		compareLed("tftDe", 2'b00, 2'(tftDe));
		compareLed("tftHSync", 2'b01, 2'(tftHSync));
		compareLed("tftVSync", 2'b01, 2'(tftVSync));
		compareColor("tftColorR", '0, tftColorR);
		compareColor("tftColorG", '0, tftColorG);
		compareColor("tftColorB", '0, tftColorB);
	endtask

	//------------------------------------------------------------------
	// Bus driver
	//------------------------------------------------------------------
	task automatic busWrite(input logic [busAdrsBit-1:0] adrs,
		input logic [usiBusWidth-1:0] data);
		@(posedge sysClk);
		usiWEd  <= 1'b1;
		usiREd  <= 1'b0;
		usiAdrs <= adrs;
		usiWd   <= data;
		modelWrite(adrs, data);
	endtask

	// Strobe is sampled on the next edge
	task automatic busRead(input logic [busAdrsBit-1:0] adrs);
		@(posedge sysClk);
		usiWEd  <= 1'b0;
		usiREd  <= 1'b1;
		usiAdrs <= adrs;
		usiWd   <= randBits(32);
		expQ.push_back(modelRead(adrs));
		issueQ.push_back(cycle + 1);
	endtask

	task automatic busIdle(input int count);
		repeat (count)
		begin
			@(posedge sysClk);
			usiWEd <= 1'b0;
			usiREd <= 1'b0;
		end
	endtask

	task automatic drainReads();
		busIdle(1);
		while (expQ.size() != 0)
			@(posedge sysClk);
	endtask

	// Read return, valid is set by the edge before the one seen here
	always @(posedge sysClk)
	begin
		if (usiRdVd === 1'b1)
		begin
			if (expQ.size() == 0)
			begin
				$display("Read valid at %0t with no read outstanding", $time);
				$display("RESULT: FAIL");
				$fatal(1, "Unexpected read valid");
			end
			else
			begin
				compareCount("usiRdVd latency", usiReadLatency, cycle - 1 - issueQ.pop_front());
				compareWord("usiRd", expQ.pop_front(), usiRd);
			end
		end
	end

	//------------------------------------------------------------------
	// Video measurement
	//------------------------------------------------------------------
	task automatic measureFrames();
		int lineTotal;
		int frameCycles;
		int deRun;
		int hsRun;
		int vsRun;
		int lastHsFall;
		int deLines;
		int frames;
		logic prevDe;
		logic prevHs;
		logic prevVs;
		lineTotal = tHd + tHf + tHp + tHb;
		frameCycles = lineTotal * (tVd + tVf + tVp + tVb);
		deRun = 0;
		hsRun = 0;
		vsRun = 0;
		lastHsFall = -1;
		deLines = 0;
		frames = 0;
		prevDe = 1'b0;
		prevHs = 1'b1;
		prevVs = 1'b1;
		// Frame opens with its first display cycle
		while (tftDe !== 1'b1)
			@(posedge sysClk);
		for (int i = 0; i < 2 * frameCycles; i++)
		begin
			if (tftDe)
				deRun++;
			else if (prevDe)
			begin
				compareCount("tftDe run", tHd, deRun);
				deRun = 0;
			end
			if (tftDe && !prevDe)
				deLines++;
			if (!tftHSync)
				hsRun++;
			if (!tftHSync && prevHs)
			begin
				if (lastHsFall >= 0)
					compareCount("tftHSync period", lineTotal, i - lastHsFall);
				lastHsFall = i;
			end
			if (tftHSync && !prevHs)
			begin
				compareCount("tftHSync low run", tHp, hsRun);
				hsRun = 0;
			end
			if (!tftVSync)
				vsRun++;
			if (!tftVSync && prevVs)
			begin
				compareCount("tftDe lines per frame", tVd, deLines);
				deLines = 0;
				frames++;
			end
			if (tftVSync && !prevVs)
			begin
				compareCount("tftVSync low run", tVp * lineTotal, vsRun);
				vsRun = 0;
			end
			compareColor("tftColorR", tftDe ? tColor[11:8] : 4'h0, tftColorR);
			compareColor("tftColorG", tftDe ? tColor[7:4] : 4'h0, tftColorG);
			compareColor("tftColorB", tftDe ? tColor[3:0] : 4'h0, tftColorB);
			compareLed("tftBackLight", 2'b01, 2'(tftBackLight));
			prevDe = tftDe;
			prevHs = tftHSync;
			prevVs = tftVSync;
			@(posedge sysClk);
		end
		compareCount("vsync pulses in two frames", 2, frames);
	endtask

	//------------------------------------------------------------------
	// Test sequence
	//------------------------------------------------------------------
	initial
	begin
		logic [busAdrsBit-1:0] adrs;
		lfsrState = 32'h36fd;
		cycle = 0;
		rstN = 1'b0;
		usiWd = '0;
		usiAdrs = '0;
		usiWEd = 1'b0;
		usiREd = 1'b0;
		resetModel();
		repeat (resetCycles) @(posedge sysClk);
		rstN <= 1'b1;

		// Reset values
		checkPins();
		checkVideoIdle();
		for (int i = 0; i < 2; i++)
			busRead(makeAdrs(gpioAdrsMap, 16'(i)));
		for (int i = 0; i < 10; i++)
			busRead(makeAdrs(vtbAdrsMap, 16'(i)));
		drainReads();

		// GPIO registers and pins
		for (int i = 0; i < 30; i++)
		begin
			adrs = makeAdrs(gpioAdrsMap, 16'(randRange(0, 2)));
			busWrite(adrs, randBits(32));
			busIdle(3);
			checkPins();
			busRead(adrs);
		end
		drainReads();

		// All offsets, unmapped ones and an unmapped block
		for (int i = 0; i < 150; i++)
		begin
			adrs = randomAdrs();
			if (randBits(1) == 1)
				busWrite(adrs, randBits(32));
			busRead(adrs);
			if (randBits(2) == 0)
				busIdle(1);
		end
		drainReads();
		busIdle(3);
		checkPins();

		// Back-to-back mix of reads and writes
		for (int i = 0; i < 80; i++)
		begin
			adrs = randomAdrs();
			if (randBits(1) == 1)
				busRead(adrs);
			else
				busWrite(adrs, randBits(32));
		end
		drainReads();

		// Small panel, programmed while disabled
		busWrite(makeAdrs(vtbAdrsMap, vtbCtrlCsr), 32'h0);
		tHd = randRange(4, 20);
		tHf = randRange(1, 6);
		tHb = randRange(1, 6);
		tHp = randRange(1, 6);
		tVd = randRange(4, 20);
		tVf = randRange(1, 6);
		tVb = randRange(1, 6);
		tVp = randRange(1, 6);
		tColor = 12'(randBits(12));
		busWrite(makeAdrs(vtbAdrsMap, vtbHdisplayCsr), 32'(tHd));
		busWrite(makeAdrs(vtbAdrsMap, vtbHfrontCsr), 32'(tHf));
		busWrite(makeAdrs(vtbAdrsMap, vtbHbackCsr), 32'(tHb));
		busWrite(makeAdrs(vtbAdrsMap, vtbHpulseCsr), 32'(tHp));
		busWrite(makeAdrs(vtbAdrsMap, vtbVdisplayCsr), 32'(tVd));
		busWrite(makeAdrs(vtbAdrsMap, vtbVfrontCsr), 32'(tVf));
		busWrite(makeAdrs(vtbAdrsMap, vtbVbackCsr), 32'(tVb));
		busWrite(makeAdrs(vtbAdrsMap, vtbVpulseCsr), 32'(tVp));
		busWrite(makeAdrs(vtbAdrsMap, vtbColorCsr), 32'(tColor));
		busIdle(4);
		checkVideoIdle();
		// Enable and backlight on
		busWrite(makeAdrs(vtbAdrsMap, vtbCtrlCsr), 32'h3);
		busIdle(1);
		measureFrames();

		busIdle(1);
		if (expQ.size() == 0)
		begin
			$display("RESULT: PASS");
			$finish;
		end
		else
		begin
			$display("Reads still outstanding at the end of the run");
			$display("RESULT: FAIL");
			$fatal(1, "Outstanding reads");
		end
	end

	initial
	begin
		#(watchdogCycles * clkPeriod);
		$display("Timeout after %0d cycles, the run did not complete", watchdogCycles);
		$display("RESULT: FAIL");
		$fatal(1, "Watchdog timeout");
	end

endmodule

//--- files.f
processorPkg.sv
usiBus.sv
gpioBlock.sv
videoCsr.sv
videoTiming.sv
processor.sv
tbProcessor.sv

//--- run.sh
#!/bin/sh
# Compile and run the processor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps -f files.f \
	--top-module tbProcessor -o simProcessor
if [ $? -ne 0 ]; then
	echo "Compile failed"
	exit 1
fi

./obj_dir/simProcessor > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
fi

if grep -q "^RESULT: PASS$" sim.log; then
	exit 0
fi
exit 1
